// File: Bender.yml
package:
  name: wisc_core

sources:
  - include_dirs:
      - src
    files:
      - src/wisc_pkg.sv
      - src/reg_file.sv
      - src/decode_stage.sv
      - src/id_ex.sv
      - src/execute_stage.sv
      - src/wisc_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/wisc_core_checker.sv
      - dv/wisc_core_tb.sv

// File: dv/wisc_core_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "wisc_params.svh"

module wisc_core_checker (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              instr_valid,
    input  wire logic              instr_ready,
    input  wire wisc_pkg::instr_u  instr,
    input  wire logic              res_valid,
    input  wire logic              res_ready,
    input  wire wisc_pkg::ex_res_t res,
    output int                     error_count,
    output int                     accepted,
    output int                     completed
);

    // architectural state, updated in acceptance order
    wisc_pkg::data_t   model_regs [`WISC_NUM_REGS];
    wisc_pkg::ex_res_t expected [$];
    wisc_pkg::ex_res_t last_res;
    logic              was_stalled;
    logic              halt_taken;

    function automatic wisc_pkg::ex_res_t predict(input wisc_pkg::instr_u w);
        wisc_pkg::ex_res_t p;
        wisc_pkg::data_t   a;
        wisc_pkg::data_t   b;
        wisc_pkg::data_t   simm;
        wisc_pkg::data_t   zimm;
        p    = '0;
        a    = model_regs[w.r.rs];
        b    = model_regs[w.r.rt];
        simm = `WISC_DATA_W'($signed(w.i.imm));
        zimm = `WISC_DATA_W'(w.i.imm);
        p.wr_en  = 1'b1;
        p.wr_reg = w.i.rd;
        case (w.r.opcode)
            wisc_pkg::RTYPE: begin
                p.wr_reg = w.r.rd;
                case (w.r.func)
                    wisc_pkg::FN_ADD: p.value = a + b;
                    wisc_pkg::FN_SUB: p.value = b - a;
                    wisc_pkg::FN_XOR: p.value = a ^ b;
                    default:          p.value = a & ~b;
                endcase
            end
            wisc_pkg::ADDI:  p.value = a + simm;
            wisc_pkg::SUBI:  p.value = simm - a;
            wisc_pkg::XORI:  p.value = a ^ zimm;
            wisc_pkg::ANDNI: p.value = a & ~zimm;
            wisc_pkg::HALT: begin
                p.wr_en = 1'b0;
                p.halt  = 1'b1;
            end
            default: p.wr_en = 1'b0;
        endcase
        return p;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    always @(negedge clk) begin
        wisc_pkg::ex_res_t exp_beat;
        if (!rst_n) begin
            for (int i = 0; i < `WISC_NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            expected.delete();
            was_stalled = 1'b0;
            halt_taken  = 1'b0;
            error_count = 0;
            accepted    = 0;
            completed   = 0;
            check_field("res_valid", res_valid, 1'b0);
        end else begin
            if (was_stalled) begin
                check_field("res_valid", res_valid, 1'b1);
                check_field("res", res, last_res);
            end
            if (halt_taken && instr_ready) begin
                $display("instr_ready went high again after HALT was accepted");
                error_count++;
            end
            if (res_valid && res_ready) begin
                completed++;
                if (expected.size() == 0) begin
                    $display("a result beat completed with no instruction outstanding");
                    error_count++;
                end else begin
                    exp_beat = expected.pop_front();
                    check_field("res.wr_en", res.wr_en, exp_beat.wr_en);
                    check_field("res.halt", res.halt, exp_beat.halt);
                    // target and value are don't-care on non-writing beats
                    if (exp_beat.wr_en) begin
                        check_field("res.wr_reg", res.wr_reg, exp_beat.wr_reg);
                        check_field("res.value", res.value, exp_beat.value);
                    end
                end
            end
            if (instr_valid && instr_ready) begin
                accepted++;
                exp_beat = predict(instr);
                expected.push_back(exp_beat);
                if (exp_beat.wr_en) begin
                    model_regs[exp_beat.wr_reg] = exp_beat.value;
                end
                if (exp_beat.halt) begin
                    halt_taken = 1'b1;
                end
            end
            was_stalled = res_valid && !res_ready;
            last_res    = res;
        end
    end

endmodule

`default_nettype wire

// File: dv/wisc_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "wisc_params.svh"

module wisc_core_tb;

    localparam int unsigned SEED         = 32'h25fe_0775;
    localparam int          WAIT_LIMIT   = 200;
    localparam int          HALT_WINDOW  = 40;
    localparam int          RANDOM_COUNT = 400;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    logic              instr_ready;
    wisc_pkg::instr_u  instr;
    logic              res_valid;
    logic              res_ready;
    wisc_pkg::ex_res_t res;
    int                error_count;
    int                accepted;
    int                completed;
    int                ready_pct;
    int                errors_before;
    wisc_pkg::instr_u  w;

    wisc_core dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res         (res)
    );

    wisc_core_checker checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res         (res),
        .error_count (error_count),
        .accepted    (accepted),
        .completed   (completed)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $finish;
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        res_ready = ($urandom_range(99) < ready_pct);
    endtask

    task automatic send_instr(input wisc_pkg::instr_u word);
        int   waited;
        logic taken;
        waited      = 0;
        taken       = 1'b0;
        instr       = word;
        instr_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready;
            next_cycle();
            waited++;
            if (!taken && waited > WAIT_LIMIT) begin
                fail_run("timeout: the DUT never accepted an instruction");
            end
        end
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (completed != accepted) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("timeout: result beats were still outstanding");
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    // mostly r1..r3 so that dependencies at both distances are common
    function automatic wisc_pkg::reg_idx_t pick_reg();
        if ($urandom_range(3) != 0) begin
            return 3'($urandom_range(3, 1));
        end
        return 3'($urandom_range(7));
    endfunction

    function automatic wisc_pkg::instr_u random_word();
        wisc_pkg::instr_u word;
        word      = `WISC_INSTR_W'($urandom());
        word.r.rs = pick_reg();
        word.r.rt = pick_reg();
        word.r.rd = pick_reg();
        case ($urandom_range(9))
            0, 1, 2, 3: word.r.opcode = wisc_pkg::RTYPE;
            4:          word.r.opcode = wisc_pkg::ADDI;
            5:          word.r.opcode = wisc_pkg::SUBI;
            6:          word.r.opcode = wisc_pkg::XORI;
            7:          word.r.opcode = wisc_pkg::ANDNI;
            8:          word.r.opcode = wisc_pkg::NOP;
            // unused codes 2..7
            default:    word.r.opcode = wisc_pkg::opcode_e'(5'd2 + 5'($urandom_range(5)));
        endcase
        return word;
    endfunction

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        res_ready     = 1'b0;
        ready_pct     = 100;
        errors_before = 0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // every register read once, each must be zero
        for (int i = 0; i < `WISC_NUM_REGS; i++) begin
            w          = '0;
            w.i.opcode = wisc_pkg::ADDI;
            w.i.rs     = 3'(i);
            w.i.rd     = 3'(i);
            send_instr(w);
        end
        wait_drain();
        end_test("reset");

        ready_pct = 60;
        repeat (RANDOM_COUNT) begin
            send_instr(random_word());
            if ($urandom_range(3) == 0) begin
                repeat ($urandom_range(2, 1)) next_cycle();
            end
        end
        wait_drain();
        end_test("random");

        ready_pct = 100;
        send_instr(random_word());
        send_instr('0);
        wait_drain();
        instr       = random_word();
        instr_valid = 1'b1;
        repeat (HALT_WINDOW) next_cycle();
        instr_valid = 1'b0;
        end_test("halt");

        if (accepted != completed) begin
            $display("the numbers of accepted and completed instructions differ");
        end
        $display("accepted %0d, completed %0d, errors %0d", accepted, completed, error_count);
        if (error_count == 0 && accepted == completed) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "wisc_params.svh"

module decode_stage (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             instr_valid,
    output logic                  instr_ready,
    input  wire wisc_pkg::instr_u instr,
    input  wire logic             advance,
    input  wire wisc_pkg::wb_t    wb,
    output wisc_pkg::id_ex_t      dec
);

    logic            halted;
    logic            accept;
    logic            is_halt;
    wisc_pkg::data_t rs_data;
    wisc_pkg::data_t rt_data;
    wisc_pkg::data_t sext_imm;
    wisc_pkg::data_t zext_imm;

    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_reg_1  (instr.r.rs),
        .rd_reg_2  (instr.r.rt),
        .rd_data_1 (rs_data),
        .rd_data_2 (rt_data),
        .wb        (wb)
    );

    assign instr_ready = advance & ~halted;
    assign accept      = instr_valid & instr_ready;
    assign is_halt     = (instr.r.opcode == wisc_pkg::HALT);

    // arithmetic immediates are signed, logical ones are not
    assign sext_imm = {{(`WISC_DATA_W-5){instr.i.imm[4]}}, instr.i.imm};
    assign zext_imm = {{(`WISC_DATA_W-5){1'b0}}, instr.i.imm};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (accept && is_halt) begin
            halted <= 1'b1;
        end
    end

    always_comb begin
        dec           = '0;
        dec.valid     = accept;
        dec.rd_reg_1  = instr.r.rs;
        dec.rd_reg_2  = instr.r.rt;
        dec.rd_data_1 = rs_data;
        dec.wr_reg    = instr.i.rd;
        dec.oprnd_2   = zext_imm;
        dec.alu_op    = wisc_pkg::ALU_ADD;
        case (instr.r.opcode)
            wisc_pkg::RTYPE: begin
                dec.has_rt  = 1'b1;
                dec.wr_en   = 1'b1;
                dec.wr_reg  = instr.r.rd;
                dec.oprnd_2 = rt_data;
                case (instr.r.func)
                    // rt - rs as ~rs + rt + 1
                    wisc_pkg::FN_SUB: begin
                        dec.alu_inv_a = 1'b1;
                        dec.alu_cin   = 1'b1;
                    end
                    wisc_pkg::FN_XOR: dec.alu_op = wisc_pkg::ALU_XOR;
                    wisc_pkg::FN_ANDN: begin
                        dec.alu_op    = wisc_pkg::ALU_ANDN;
                        dec.alu_inv_b = 1'b1;
                    end
                    default: dec.alu_op = wisc_pkg::ALU_ADD;
                endcase
            end
            wisc_pkg::ADDI: begin
                dec.wr_en   = 1'b1;
                dec.oprnd_2 = sext_imm;
            end
            wisc_pkg::SUBI: begin
                dec.wr_en     = 1'b1;
                dec.oprnd_2   = sext_imm;
                dec.alu_inv_a = 1'b1;
                dec.alu_cin   = 1'b1;
            end
            wisc_pkg::XORI: begin
                dec.wr_en  = 1'b1;
                dec.alu_op = wisc_pkg::ALU_XOR;
            end
            wisc_pkg::ANDNI: begin
                dec.wr_en     = 1'b1;
                dec.alu_op    = wisc_pkg::ALU_ANDN;
                dec.alu_inv_b = 1'b1;
            end
            wisc_pkg::HALT: dec.halt = 1'b1;
            // nop and illegal opcodes leave everything clear
            default: dec.wr_en = 1'b0;
        endcase
    end

    // once HALT is taken the input side stays closed
    no_accept_after_halt: assert property (
        @(posedge clk) disable iff (!rst_n)
        (accept && is_halt) |=> (halted && !(instr_valid && instr_ready))
    );

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire wisc_pkg::id_ex_t ex_in,
    output logic                  advance,
    output logic                  res_valid,
    input  wire logic             res_ready,
    output wisc_pkg::ex_res_t     res,
    output wisc_pkg::wb_t         wb
);

    logic              fwd_1;
    logic              fwd_2;
    logic              held_wr;
    wisc_pkg::data_t   opnd_a;
    wisc_pkg::data_t   opnd_b;
    wisc_pkg::data_t   alu_a;
    wisc_pkg::data_t   alu_b;
    wisc_pkg::data_t   alu_out;
    wisc_pkg::ex_res_t next_res;

    // result register empty or emptying this cycle
    assign advance = ~res_valid | res_ready;

    // distance-1 forward from the held result
    assign held_wr = res_valid & res.wr_en;
    assign fwd_1   = held_wr & (res.wr_reg == ex_in.rd_reg_1);
    assign fwd_2   = held_wr & ex_in.has_rt & (res.wr_reg == ex_in.rd_reg_2);

    assign opnd_a = fwd_1 ? res.value : ex_in.rd_data_1;
    assign opnd_b = fwd_2 ? res.value : ex_in.oprnd_2;

    assign alu_a = ex_in.alu_inv_a ? ~opnd_a : opnd_a;
    assign alu_b = ex_in.alu_inv_b ? ~opnd_b : opnd_b;

    always_comb begin
        case (ex_in.alu_op)
            wisc_pkg::ALU_XOR:  alu_out = alu_a ^ alu_b;
            wisc_pkg::ALU_ANDN: alu_out = alu_a & alu_b;
            // carry-in completes the two's complement for subtract
            default: alu_out = alu_a + alu_b + {{($bits(alu_out)-1){1'b0}}, ex_in.alu_cin};
        endcase
    end

    always_comb begin
        next_res.wr_en  = ex_in.wr_en;
        next_res.wr_reg = ex_in.wr_reg;
        next_res.value  = alu_out;
        next_res.halt   = ex_in.halt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else if (advance) begin
            res_valid <= ex_in.valid;
            res       <= next_res;
        end
    end

    // retire into the register file as the beat leaves
    always_comb begin
        wb.en   = res_valid & res_ready & res.wr_en;
        wb.idx  = res.wr_reg;
        wb.data = res.value;
    end

    res_held_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res))
    );

endmodule

`default_nettype wire

// File: src/id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             advance,
    input  wire wisc_pkg::id_ex_t in_bundle,
    output wisc_pkg::id_ex_t      out_bundle
);

    wisc_pkg::id_ex_t gated;

    // a bubble must not write, forward on rt or halt
    always_comb begin
        gated        = in_bundle;
        gated.has_rt = in_bundle.has_rt & in_bundle.valid;
        gated.wr_en  = in_bundle.wr_en & in_bundle.valid;
        gated.halt   = in_bundle.halt & in_bundle.valid;
    end

    // holds while execute cannot take a new entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_bundle <= '0;
        end else if (advance) begin
            out_bundle <= gated;
        end
    end

    bubble_is_nop: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_bundle.valid |-> (!out_bundle.wr_en && !out_bundle.halt)
    );

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "wisc_params.svh"

module reg_file (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire wisc_pkg::reg_idx_t rd_reg_1,
    input  wire wisc_pkg::reg_idx_t rd_reg_2,
    output wisc_pkg::data_t        rd_data_1,
    output wisc_pkg::data_t        rd_data_2,
    input  wire wisc_pkg::wb_t     wb
);

    wisc_pkg::data_t regs [`WISC_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WISC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // write-through, so a reader two stages behind the writer sees the new value
    always_comb begin
        if (wb.en && (wb.idx == rd_reg_1)) begin
            rd_data_1 = wb.data;
        end else begin
            rd_data_1 = regs[rd_reg_1];
        end
        if (wb.en && (wb.idx == rd_reg_2)) begin
            rd_data_2 = wb.data;
        end else begin
            rd_data_2 = regs[rd_reg_2];
        end
    end

    // a retiring beat must name a real register
    wb_idx_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.en |-> !$isunknown(wb.idx)
    );

endmodule

`default_nettype wire

// File: src/wisc_core.sv
`timescale 1ns/1ps
`default_nettype none

module wisc_core (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             instr_valid,
    output logic                  instr_ready,
    input  wire wisc_pkg::instr_u instr,
    output logic                  res_valid,
    input  wire logic             res_ready,
    output wisc_pkg::ex_res_t     res
);

    // one enable for the whole pipe
    logic             advance;
    wisc_pkg::wb_t    wb;
    wisc_pkg::id_ex_t dec;
    wisc_pkg::id_ex_t ex_in;

    decode_stage decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .advance     (advance),
        .wb          (wb),
        .dec         (dec)
    );

    id_ex id_ex_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .in_bundle  (dec),
        .out_bundle (ex_in)
    );

    execute_stage execute_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_in     (ex_in),
        .advance   (advance),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// File: src/wisc_params.svh
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// datapath word width
`define WISC_DATA_W    16

// register index width and register count
`define WISC_REG_W     3
`define WISC_NUM_REGS  8

// fixed instruction word width
`define WISC_INSTR_W   16

`endif

// File: src/wisc_pkg.sv
`default_nettype none
`include "wisc_params.svh"

package wisc_pkg;

    typedef logic [`WISC_DATA_W-1:0] data_t;
    typedef logic [`WISC_REG_W-1:0]  reg_idx_t;

    // major opcode, always in bits [15:11]
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        RTYPE = 5'b11011
    } opcode_e;

    // function field of RTYPE
    typedef enum logic [1:0] {
        FN_ADD  = 2'b00,
        FN_SUB  = 2'b01,
        FN_XOR  = 2'b10,
        FN_ANDN = 2'b11
    } func_e;

    // andn ands the conditioned operands, decode sets inv_b for it
    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_XOR  = 2'b01,
        ALU_ANDN = 2'b10
    } alu_op_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        func_e    func;
    } instr_r_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rs;
        reg_idx_t   rd;
        logic [4:0] imm;
    } instr_i_t;

    // opcode lines up in both views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic     valid;
        data_t    rd_data_1;
        data_t    oprnd_2;
        reg_idx_t rd_reg_1;
        reg_idx_t rd_reg_2;
        reg_idx_t wr_reg;
        logic     has_rt;
        alu_op_e  alu_op;
        logic     alu_inv_a;
        logic     alu_inv_b;
        logic     alu_cin;
        logic     wr_en;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        logic     wr_en;
        reg_idx_t wr_reg;
        data_t    value;
        logic     halt;
    } ex_res_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        data_t    data;
    } wb_t;

endpackage

`default_nettype wire

// File: wisc_core.f
+incdir+src
src/wisc_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/id_ex.sv
src/execute_stage.sv
src/wisc_core.sv
dv/wisc_core_checker.sv
dv/wisc_core_tb.sv
